// File: adc_pkg.sv
package adc_pkg;

  // one ADC sample
  localparam int SAMPLE_W = 24;

  // samples packed into one board word
  localparam int SAMPLES_PER_WORD = 4;

  // full board word
  localparam int WORD_W = SAMPLE_W * SAMPLES_PER_WORD;

  // channels in one frame
  localparam int CHANNELS = 64;

  // words needed for a whole frame
  localparam int WORDS_PER_FRAME = CHANNELS / SAMPLES_PER_WORD;

  // peer boards sharing the output stream
  localparam int N_BOARDS = 2;
  localparam int BOARD_W = (N_BOARDS > 1) ? $clog2(N_BOARDS) : 1;

  // per-board dual-clock FIFO
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);

  typedef logic [SAMPLE_W-1:0] sample_t;

  typedef logic [WORD_W-1:0] adc_word_t;

  // sync flag travels with its sample through the FIFO
  typedef struct packed {
    logic    sync;
    sample_t sample;
  } fifo_entry_t;

  typedef logic [BOARD_W-1:0] board_id_t;

endpackage

// File: adc_stream_mux.sv
`timescale 1ns/1ps

module adc_stream_mux (
  input  logic               wr_clk,
  input  logic               rst_n,
  input  adc_pkg::adc_word_t din,
  input  logic               dvld,
  output adc_pkg::sample_t   mux_sample,
  output logic               mux_sync,
  output logic               mux_vld
);

  // held word, shifted down by one sample per cycle
  adc_pkg::adc_word_t word_q;

  // which sample of the word is on the output
  logic [$clog2(adc_pkg::SAMPLES_PER_WORD)-1:0] slot_q;

  // index of the word being unpacked within its frame
  logic [$clog2(adc_pkg::WORDS_PER_FRAME)-1:0] word_cnt_q;

  // a word is being unpacked
  logic busy_q;
  logic last_slot;

  assign last_slot = busy_q && (slot_q == adc_pkg::SAMPLES_PER_WORD - 1);

  // slot, word and busy tracking
  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q     <= 1'b0;
      slot_q     <= '0;
      word_cnt_q <= '0;
    end else begin
      // advance the frame position when a word is finished
      if (last_slot) begin
        if (word_cnt_q == adc_pkg::WORDS_PER_FRAME - 1) begin
          word_cnt_q <= '0;
        end else begin
          word_cnt_q <= word_cnt_q + 1'b1;
        end
      end
      // new word may land on the same edge as the last slot
      if (dvld) begin
        busy_q <= 1'b1;
        slot_q <= '0;
      end else if (last_slot) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        slot_q <= slot_q + 1'b1;
      end
    end
  end

  // word data, lowest sample leaves first
  always_ff @(posedge wr_clk) begin
    if (dvld) begin
      word_q <= din;
    end else if (busy_q) begin
      word_q <= word_q >> adc_pkg::SAMPLE_W;
    end
  end

  assign mux_sample = word_q[adc_pkg::SAMPLE_W-1:0];
  assign mux_vld    = busy_q;

  // frame start is slot 0 of word 0
  assign mux_sync = busy_q && (slot_q == '0) && (word_cnt_q == '0);

  // source must leave room for all samples of the previous word
  a_dvld_spacing: assert property (
    @(posedge wr_clk) disable iff (!rst_n)
    dvld |=> !dvld [*adc_pkg::SAMPLES_PER_WORD-1]
  ) else $error("dvld closer than one word apart");

endmodule

// File: async_sample_fifo.sv
`timescale 1ns/1ps

module async_sample_fifo (
  input  logic                 wr_clk,
  input  logic                 wr_rst_n,
  input  logic                 wr_en,
  input  adc_pkg::fifo_entry_t wr_data,
  input  logic                 rd_clk,
  input  logic                 rd_rst_n,
  input  logic                 rd_en,
  output adc_pkg::fifo_entry_t rd_data,
  output logic                 empty,
  output logic                 overflow
);

  // storage
  adc_pkg::fifo_entry_t mem [adc_pkg::FIFO_DEPTH];

  // pointers carry one extra wrap bit
  logic [adc_pkg::FIFO_AW:0] wr_bin;
  logic [adc_pkg::FIFO_AW:0] wr_gray;
  logic [adc_pkg::FIFO_AW:0] wr_bin_nxt;
  logic [adc_pkg::FIFO_AW:0] rd_bin;
  logic [adc_pkg::FIFO_AW:0] rd_gray;
  logic [adc_pkg::FIFO_AW:0] rd_bin_nxt;

  // read pointer seen in the write domain
  logic [adc_pkg::FIFO_AW:0] rd_gray_ws1;
  logic [adc_pkg::FIFO_AW:0] rd_gray_ws2;

  // write pointer seen in the read domain
  logic [adc_pkg::FIFO_AW:0] wr_gray_rs1;
  logic [adc_pkg::FIFO_AW:0] wr_gray_rs2;

  logic full;
  logic wr_push;
  logic rd_pop;

  function automatic logic [adc_pkg::FIFO_AW:0] bin2gray(
    input logic [adc_pkg::FIFO_AW:0] bin
  );
    return bin ^ (bin >> 1);
  endfunction

  // write domain

  assign wr_bin_nxt = wr_bin + 1'b1;

  // full when the top two gray bits differ and the rest match
  assign full = (wr_gray == {~rd_gray_ws2[adc_pkg::FIFO_AW:adc_pkg::FIFO_AW-1],
                             rd_gray_ws2[adc_pkg::FIFO_AW-2:0]});

  // writes into a full FIFO are dropped
  assign wr_push = wr_en && !full;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin      <= '0;
      wr_gray     <= '0;
      rd_gray_ws1 <= '0;
      rd_gray_ws2 <= '0;
      overflow    <= 1'b0;
    end else begin
      rd_gray_ws1 <= rd_gray;
      rd_gray_ws2 <= rd_gray_ws1;
      // one pulse per dropped sample
      overflow    <= wr_en && full;
      if (wr_push) begin
        wr_bin  <= wr_bin_nxt;
        wr_gray <= bin2gray(wr_bin_nxt);
      end
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_push) begin
      mem[wr_bin[adc_pkg::FIFO_AW-1:0]] <= wr_data;
    end
  end

  // read domain

  assign rd_bin_nxt = rd_bin + 1'b1;
  assign empty      = (rd_gray == wr_gray_rs2);
  assign rd_pop     = rd_en && !empty;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin      <= '0;
      rd_gray     <= '0;
      wr_gray_rs1 <= '0;
      wr_gray_rs2 <= '0;
    end else begin
      wr_gray_rs1 <= wr_gray;
      wr_gray_rs2 <= wr_gray_rs1;
      if (rd_pop) begin
        rd_bin  <= rd_bin_nxt;
        rd_gray <= bin2gray(rd_bin_nxt);
      end
    end
  end

  // registered read port
  always_ff @(posedge rd_clk) begin
    if (rd_pop) begin
      rd_data <= mem[rd_bin[adc_pkg::FIFO_AW-1:0]];
    end
  end

  // the arbiter only pops non-empty FIFOs
  a_no_underflow: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    rd_en |-> !empty
  ) else $error("read of an empty FIFO");

endmodule

// File: adc_retime.sv
`timescale 1ns/1ps

module adc_retime (
  input  logic                 wr_clk,
  input  logic                 rd_clk,
  input  logic                 rst_n,
  input  adc_pkg::adc_word_t   din,
  input  logic                 dvld,
  input  logic                 pop,
  output adc_pkg::fifo_entry_t rd_data,
  output logic                 rd_vld,
  output logic                 empty,
  output logic                 fifo_of
);

  // bit 0 is the write domain, bit 1 the read domain
  logic [1:0] dom_clk;
  logic [1:0] dom_rst_n;
  logic       wr_rst_n;
  logic       rd_rst_n;

  // mux outputs
  adc_pkg::sample_t mux_sample;
  logic             mux_sync;
  logic             mux_vld;

  // pipeline stage in front of the FIFO write port
  adc_pkg::fifo_entry_t pipe_entry;
  logic                 pipe_vld;

  // FIFO read port and the pop that loaded it
  adc_pkg::fifo_entry_t fifo_rd_data;
  logic                 pop_q;

  assign dom_clk = {rd_clk, wr_clk};

  // async assert, three-flop release per domain
  for (genvar d = 0; d < 2; d++) begin : g_rst_sync
    logic [2:0] sync_q;
    always_ff @(posedge dom_clk[d] or negedge rst_n) begin
      if (!rst_n) begin
        sync_q <= '0;
      end else begin
        sync_q <= {sync_q[1:0], 1'b1};
      end
    end
    assign dom_rst_n[d] = sync_q[2];
  end

  assign wr_rst_n = dom_rst_n[0];
  assign rd_rst_n = dom_rst_n[1];

  adc_stream_mux u_adc_stream_mux (
    .wr_clk     (wr_clk),
    .rst_n      (wr_rst_n),
    .din        (din),
    .dvld       (dvld),
    .mux_sample (mux_sample),
    .mux_sync   (mux_sync),
    .mux_vld    (mux_vld)
  );

  // one cycle between mux and FIFO
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      pipe_vld <= 1'b0;
    end else begin
      pipe_vld <= mux_vld;
    end
  end

  always_ff @(posedge wr_clk) begin
    pipe_entry.sync   <= mux_sync;
    pipe_entry.sample <= mux_sample;
  end

  async_sample_fifo u_async_sample_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (pipe_vld),
    .wr_data  (pipe_entry),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (pop),
    .rd_data  (fifo_rd_data),
    .empty    (empty),
    .overflow (fifo_of)
  );

  // FIFO data is fresh the cycle after a pop
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      pop_q  <= 1'b0;
      rd_vld <= 1'b0;
    end else begin
      pop_q  <= pop;
      rd_vld <= pop_q;
    end
  end

  // output register, loaded only with popped entries
  always_ff @(posedge rd_clk) begin
    if (pop_q) begin
      rd_data <= fifo_rd_data;
    end
  end

endmodule

// File: readout_arbiter.sv
`timescale 1ns/1ps

module readout_arbiter (
  input  logic                          rd_clk,
  input  logic                          rst_n,
  input  logic                          rd_en,
  input  logic [adc_pkg::N_BOARDS-1:0]  empty,
  input  adc_pkg::fifo_entry_t          rd_data [adc_pkg::N_BOARDS],
  input  logic [adc_pkg::N_BOARDS-1:0]  rd_vld,
  output logic [adc_pkg::N_BOARDS-1:0]  pop,
  output adc_pkg::sample_t              dout,
  output logic                          dout_sync,
  output adc_pkg::board_id_t            dout_board,
  output logic                          dout_vld
);

  // last board granted, search starts after it
  adc_pkg::board_id_t last_q;
  adc_pkg::board_id_t grant_board;
  logic               grant_found;

  // board number follows the pop through FIFO and output register
  adc_pkg::board_id_t board_q1;
  adc_pkg::board_id_t board_q2;

  adc_pkg::fifo_entry_t sel_entry;

  // first non-empty board after last_q, wrapping round
  always_comb begin : rr_search
    int idx;
    idx         = 0;
    grant_found = 1'b0;
    grant_board = last_q;
    for (int k = 1; k <= adc_pkg::N_BOARDS; k++) begin
      idx = (int'(last_q) + k) % adc_pkg::N_BOARDS;
      if (!grant_found && !empty[idx]) begin
        grant_found = 1'b1;
        grant_board = adc_pkg::board_id_t'(idx);
      end
    end
  end

  // combinational pop so empty is seen the same cycle
  always_comb begin
    pop = '0;
    if (rd_en && grant_found) begin
      pop[grant_board] = 1'b1;
    end
  end

  // round-robin pointer and board-number pipe
  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      last_q   <= adc_pkg::board_id_t'(adc_pkg::N_BOARDS - 1);
      board_q1 <= '0;
      board_q2 <= '0;
    end else begin
      if (|pop) begin
        last_q <= grant_board;
      end
      board_q1 <= grant_board;
      board_q2 <= board_q1;
    end
  end

  // shared bus driven from the board popped two cycles ago
  assign sel_entry  = rd_data[board_q2];
  assign dout       = sel_entry.sample;
  assign dout_vld   = rd_vld[board_q2];
  assign dout_sync  = sel_entry.sync && dout_vld;
  assign dout_board = board_q2;

  // round trip through the retime read registers
  a_pop_to_dout: assert property (
    @(posedge rd_clk) disable iff (!rst_n)
    (|pop) |-> ##2 dout_vld
  ) else $error("popped sample did not reach dout");

endmodule

// File: adc_readout_top.sv
`timescale 1ns/1ps

module adc_readout_top (
  input  logic                          wr_clk,
  input  logic                          rd_clk,
  input  logic                          rst_n,
  input  adc_pkg::adc_word_t            din [adc_pkg::N_BOARDS],
  input  logic [adc_pkg::N_BOARDS-1:0]  dvld,
  input  logic                          rd_en,
  output adc_pkg::sample_t              dout,
  output logic                          dout_sync,
  output adc_pkg::board_id_t            dout_board,
  output logic                          dout_vld,
  output logic [adc_pkg::N_BOARDS-1:0]  fifo_of
);

  // per-board read side, registered in each retime block
  adc_pkg::fifo_entry_t rd_data [adc_pkg::N_BOARDS];
  logic [adc_pkg::N_BOARDS-1:0] rd_vld;

  // FIFO state to the arbiter and pops back
  logic [adc_pkg::N_BOARDS-1:0] empty;
  logic [adc_pkg::N_BOARDS-1:0] pop;

  // one retime path per board
  for (genvar b = 0; b < adc_pkg::N_BOARDS; b++) begin : g_board
    adc_retime u_adc_retime (
      .wr_clk  (wr_clk),
      .rd_clk  (rd_clk),
      .rst_n   (rst_n),
      .din     (din[b]),
      .dvld    (dvld[b]),
      .pop     (pop[b]),
      .rd_data (rd_data[b]),
      .rd_vld  (rd_vld[b]),
      .empty   (empty[b]),
      .fifo_of (fifo_of[b])
    );
  end

  // merges the boards onto the tagged stream
  readout_arbiter u_readout_arbiter (
    .rd_clk     (rd_clk),
    .rst_n      (rst_n),
    .rd_en      (rd_en),
    .empty      (empty),
    .rd_data    (rd_data),
    .rd_vld     (rd_vld),
    .pop        (pop),
    .dout       (dout),
    .dout_sync  (dout_sync),
    .dout_board (dout_board),
    .dout_vld   (dout_vld)
  );

endmodule

// File: tb_adc_readout.sv
`timescale 1ns/1ps

module tb_adc_readout;

  localparam int NB = adc_pkg::N_BOARDS;
  localparam int SPW = adc_pkg::SAMPLES_PER_WORD;
  localparam int WR_PERIOD = 8;
  localparam int RD_PERIOD = 6;
  localparam int RESET_CYCLES = 8;

  // words sent per test
  localparam int T1_WORDS = 20;
  localparam int T2_WORDS = 40;
  localparam int T3_WORDS = 24;
  localparam int T4_WORDS = 8;
  localparam int T5_PRE = 3;
  localparam int T5_WORDS = 20;
  localparam int TOTAL_WORDS = T1_WORDS + T2_WORDS + 2 * T3_WORDS + T4_WORDS + T5_PRE + T5_WORDS;

  // wr_clk cycles per word at the widest gap used
  localparam int WORD_CYCLES = 8;
  localparam int PAUSE_CYCLES = 64;
  localparam int IDLE_RD_CYCLES = 40;
  localparam int DRAIN_LIMIT = 300;
  localparam int WATCHDOG_NS =
    (TOTAL_WORDS * WORD_CYCLES + 3 * (2 * RESET_CYCLES + 1) + PAUSE_CYCLES) * WR_PERIOD +
    (5 * (DRAIN_LIMIT + 8) + IDLE_RD_CYCLES + 10) * RD_PERIOD + 2000;

  logic                   wr_clk;
  logic                   rd_clk;
  logic                   rst_n;
  adc_pkg::adc_word_t     din [NB];
  logic [NB-1:0]          dvld;
  logic                   rd_en;
  adc_pkg::sample_t       dout;
  logic                   dout_sync;
  adc_pkg::board_id_t     dout_board;
  logic                   dout_vld;
  logic [NB-1:0]          fifo_of;

  // expected entries, one queue per board
  adc_pkg::fifo_entry_t exp_q [NB][$];
  int word_idx [NB];
  int of_count [NB];

  integer seed = 64809;
  int errors = 0;
  int test_err_base = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int sync_seen = 0;
  int samples_seen = 0;
  // board that alone may appear on dout, -1 for any
  int only_board = -1;
  int last_grant = NB - 1;

  adc_readout_top u_adc_readout_top (
    .wr_clk     (wr_clk),
    .rd_clk     (rd_clk),
    .rst_n      (rst_n),
    .din        (din),
    .dvld       (dvld),
    .rd_en      (rd_en),
    .dout       (dout),
    .dout_sync  (dout_sync),
    .dout_board (dout_board),
    .dout_vld   (dout_vld),
    .fifo_of    (fifo_of)
  );

  initial begin
    wr_clk = 1'b0;
    forever #(WR_PERIOD / 2) wr_clk = ~wr_clk;
  end

  // offset so no rd_clk edge meets a wr-side input change
  initial begin
    rd_clk = 1'b0;
    #1.5;
    forever #(RD_PERIOD / 2) rd_clk = ~rd_clk;
  end

  // sample and sync flag for one slot of a word, frame rule included
  function automatic adc_pkg::fifo_entry_t expected_entry(input adc_pkg::adc_word_t word,
                                                          input int slot, input int widx);
    adc_pkg::fifo_entry_t e;
    e.sample = word[slot * adc_pkg::SAMPLE_W +: adc_pkg::SAMPLE_W];
    e.sync   = (slot == 0) && (widx % adc_pkg::WORDS_PER_FRAME == 0);
    return e;
  endfunction

  // round robin: first non-empty board after the last grant
  function automatic int expected_grant(input int last, input logic [NB-1:0] empty_v,
                                        input logic en);
    int b;
    if (!en) begin
      return -1;
    end
    for (int k = 1; k <= NB; k++) begin
      b = (last + k) % NB;
      if (!empty_v[b]) begin
        return b;
      end
    end
    return -1;
  endfunction

  function automatic adc_pkg::adc_word_t rand_word();
    return {$random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int b = 0; b < NB; b++) begin
      n += exp_q[b].size();
    end
    return n;
  endfunction

  task automatic check_sample(input string name, input adc_pkg::sample_t got,
                              input adc_pkg::sample_t exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_board(input string name, input adc_pkg::board_id_t got,
                             input adc_pkg::board_id_t exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_pop(input string name, input logic [NB-1:0] got,
                           input logic [NB-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // compare each output sample with the head of its board's queue
  always @(negedge rd_clk) begin : compare_outputs
    adc_pkg::fifo_entry_t exp_e;
    if (rst_n && dout_vld) begin
      samples_seen++;
      if (dout_sync) begin
        sync_seen++;
      end
      if (only_board >= 0) begin
        check_board("dout_board", dout_board, adc_pkg::board_id_t'(only_board));
      end
      if (exp_q[dout_board].size() == 0) begin
        errors++;
        $display("sample 0x%h from board %0d arrived with nothing pending", dout, dout_board);
      end else begin
        exp_e = exp_q[dout_board].pop_front();
        check_sample("dout", dout, exp_e.sample);
        check_bit("dout_sync", dout_sync, exp_e.sync);
      end
    end
  end

  // pop pattern against the round-robin rule
  always @(negedge rd_clk) begin : check_grants
    int exp_b;
    logic [NB-1:0] exp_pop;
    if (!rst_n) begin
      last_grant = NB - 1;
    end else begin
      exp_b   = expected_grant(last_grant, u_adc_readout_top.empty, rd_en);
      exp_pop = '0;
      if (exp_b >= 0) begin
        exp_pop[exp_b] = 1'b1;
        last_grant     = exp_b;
      end
      check_pop("pop", u_adc_readout_top.pop, exp_pop);
    end
  end

  // dropped-sample pulses per board
  always @(negedge wr_clk) begin
    if (rst_n) begin
      for (int b = 0; b < NB; b++) begin
        if (fifo_of[b]) begin
          of_count[b]++;
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic apply_reset();
    @(posedge wr_clk);
    #1;
    rst_n = 1'b0;
    // pending data is lost and the frame count restarts
    for (int b = 0; b < NB; b++) begin
      exp_q[b].delete();
      word_idx[b] = 0;
    end
    repeat (RESET_CYCLES) @(posedge wr_clk);
    #1;
    rst_n = 1'b1;
    // let both reset synchronizers release
    repeat (RESET_CYCLES) @(posedge wr_clk);
  endtask

  task automatic set_rd_en(input logic v);
    @(posedge rd_clk);
    #1;
    rd_en = v;
  endtask

  // one word on dvld, then 3 + gap idle cycles
  task automatic send_word(input int b, input adc_pkg::adc_word_t w, input int gap);
    @(posedge wr_clk);
    #1;
    din[b]  = w;
    dvld[b] = 1'b1;
    for (int s = 0; s < SPW; s++) begin
      exp_q[b].push_back(expected_entry(w, s, word_idx[b]));
    end
    word_idx[b]++;
    @(posedge wr_clk);
    #1;
    dvld[b] = 1'b0;
    repeat (2 + gap) @(posedge wr_clk);
  endtask

  task automatic stream_words(input int b, input int n, input int gap, input int offset);
    repeat (offset) @(posedge wr_clk);
    for (int i = 0; i < n; i++) begin
      send_word(b, rand_word(), gap);
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (pending_count() != 0 && cycles < DRAIN_LIMIT) begin
      @(posedge rd_clk);
      cycles++;
    end
    if (pending_count() != 0) begin
      errors++;
      $display("outputs did not drain, %0d samples never arrived", pending_count());
    end
    // tail window catches surplus samples
    repeat (8) @(posedge rd_clk);
  endtask

  task automatic begin_test();
    test_err_base = errors;
    sync_seen     = 0;
    samples_seen  = 0;
    for (int b = 0; b < NB; b++) begin
      of_count[b] = 0;
    end
  endtask

  task automatic end_test(input string name, input int exp_overflows);
    check_count("fifo_of pulses", of_count[0] + of_count[1], exp_overflows);
    tests_run++;
    if (errors > test_err_base) begin
      tests_failed++;
      $display("test %s: fail (%0d errors)", name, errors - test_err_base);
    end else begin
      $display("test %s: pass", name);
    end
  endtask

  initial begin : main
    int drops;
    rst_n = 1'b0;
    rd_en = 1'b0;
    dvld  = '0;
    for (int b = 0; b < NB; b++) begin
      din[b]      = '0;
      word_idx[b] = 0;
      of_count[b] = 0;
    end
    apply_reset();

    // single board, order and tag
    begin_test();
    only_board = 0;
    set_rd_en(1'b1);
    stream_words(0, T1_WORDS, 0, 0);
    wait_drain();
    end_test("1 single board order", 0);

    // frame sync from the first word after reset
    begin_test();
    apply_reset();
    only_board = 1;
    stream_words(1, T2_WORDS, 0, 0);
    wait_drain();
    check_count("dout_sync count", sync_seen,
                (T2_WORDS + adc_pkg::WORDS_PER_FRAME - 1) / adc_pkg::WORDS_PER_FRAME);
    end_test("2 frame sync", 0);

    // both boards, round robin and no loss
    begin_test();
    only_board = -1;
    fork
      stream_words(0, T3_WORDS, 4, 0);
      stream_words(1, T3_WORDS, 4, 3);
    join
    wait_drain();
    check_count("samples delivered", samples_seen, 2 * T3_WORDS * SPW);
    end_test("3 two boards interleaved", 0);

    // back-pressure, oldest FIFO_DEPTH samples survive
    begin_test();
    only_board = 0;
    set_rd_en(1'b0);
    stream_words(0, T4_WORDS, 0, 0);
    drops = T4_WORDS * SPW - adc_pkg::FIFO_DEPTH;
    while (exp_q[0].size() > adc_pkg::FIFO_DEPTH) begin
      void'(exp_q[0].pop_back());
    end
    repeat (PAUSE_CYCLES) @(posedge wr_clk);
    check_count("fifo_of[0] pulses", of_count[0], drops);
    check_count("fifo_of[1] pulses", of_count[1], 0);
    check_count("dout_vld while paused", samples_seen, 0);
    set_rd_en(1'b1);
    wait_drain();
    check_count("samples after pause", samples_seen, adc_pkg::FIFO_DEPTH);
    end_test("4 overflow", drops);

    // reset with data pending, then a fresh frame
    begin_test();
    only_board = 0;
    set_rd_en(1'b0);
    stream_words(0, T5_PRE, 0, 0);
    apply_reset();
    set_rd_en(1'b1);
    repeat (IDLE_RD_CYCLES) @(posedge rd_clk);
    check_count("dout_vld after reset", samples_seen, 0);
    stream_words(0, T5_WORDS, 0, 0);
    wait_drain();
    check_count("dout_sync count", sync_seen,
                (T5_WORDS + adc_pkg::WORDS_PER_FRAME - 1) / adc_pkg::WORDS_PER_FRAME);
    end_test("5 reset mid-stream", 0);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
adc_pkg.sv
adc_stream_mux.sv
async_sample_fifo.sv
adc_retime.sv
readout_arbiter.sv
adc_readout_top.sv
tb_adc_readout.sv

// File: Bender.yml
package:
  name: adc_readout

sources:
  - adc_pkg.sv
  - adc_stream_mux.sv
  - async_sample_fifo.sv
  - adc_retime.sv
  - readout_arbiter.sv
  - adc_readout_top.sv
  - target: test
    files:
      - tb_adc_readout.sv
